/* files.f */
+incdir+design
design/screenPkg.sv
design/screenBuses.sv
design/screenTiming.sv
design/displayConfig.sv
design/lineBuffer.sv
design/graphicsWindow.sv
design/pixelMixer.sv
design/screens.sv
tests/screensTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= screensTb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard design/*.svh)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the run fails unless the pass line appears in the output
run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* tests/screensTb.sv */
`include "screen_macros.svh"

module screensTb;
  timeunit 1ns;
  timeprecision 100ps;

  // six tests of up to three frames each
  localparam int timeoutCycles = 6 * 3 * `H_TOTAL * `V_TOTAL + 1000;

  logic pixelClockIn;
  logic arstN;
  logic cfgWrite;
  logic [1:0] cfgAddress;
  logic [15:0] cfgData;
  logic wordValid;
  logic [31:0] wordData;
  logic lineCredit;
  logic [4:0] red;
  logic [5:0] green;
  logic [4:0] blue;
  logic horizontalSync;
  logic verticalSync;
  logic activePixel;

  int errorCount;
  int checkCount;
  int cycleCount;
  int frameCredits;
  int modelWidth;
  int modelHeight;
  logic modelGray;
  logic modelDouble;
  logic [15:0] modelBorder;
  logic senderRun;
  logic [31:0] sentWords [$];

  screens UUT (
    .pixelClockIn   (pixelClockIn),
    .arstN          (arstN),
    .cfgWrite       (cfgWrite),
    .cfgAddress     (cfgAddress),
    .cfgData        (cfgData),
    .wordValid      (wordValid),
    .wordData       (wordData),
    .lineCredit     (lineCredit),
    .red            (red),
    .green          (green),
    .blue           (blue),
    .horizontalSync (horizontalSync),
    .verticalSync   (verticalSync),
    .activePixel    (activePixel)
  );

  initial pixelClockIn = 1'b0;
  always #4 pixelClockIn = ~pixelClockIn;

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  // words per window line, both divisions rounded up
  function automatic int lineWordCount();
    int sourcePixels;
    sourcePixels = modelDouble ? (modelWidth + 1) / 2 : modelWidth;
    if (modelGray)
      return (sourcePixels + 3) / 4;
    return (sourcePixels + 1) / 2;
  endfunction

  function automatic logic [15:0] expectedPixel(input int frame, input int line,
                                                input int column);
    int top;
    int left;
    int source;
    int wordIndex;
    logic [31:0] word;
    logic [7:0] grayByte;
    top = (`V_ACTIVE - modelHeight) / 2;
    left = (`H_ACTIVE - modelWidth) / 2;
    if (line < top || line >= top + modelHeight || column < left || column >= left + modelWidth)
      return modelBorder;
    source = modelDouble ? (column - left) / 2 : column - left;
    // source lines run on across frames
    wordIndex = (frame * modelHeight + line - top) * lineWordCount() +
                (modelGray ? source / 4 : source / 2);
    if (wordIndex >= sentWords.size())
    begin
      $display("window line %0d was shown before its words were sent", line - top);
      errorCount++;
      return modelBorder;
    end
    word = sentWords[wordIndex];
    if (modelGray)
    begin
      grayByte = word[8 * (source % 4) +: 8];
      return {grayByte[7:3], grayByte[7:2], grayByte[7:3]};
    end
    return (source % 2) ? word[31:16] : word[15:0];
  endfunction

  task automatic resetDut();
    arstN = 1'b0;
    cfgWrite = 1'b0;
    wordValid = 1'b0;
    repeat (4) @(posedge pixelClockIn);
    #1;
    arstN = 1'b1;
  endtask

  task automatic writeRegister(input logic [1:0] address, input logic [15:0] data);
    @(posedge pixelClockIn);
    #1;
    cfgWrite = 1'b1;
    cfgAddress = address;
    cfgData = data;
    @(posedge pixelClockIn);
    #1;
    cfgWrite = 1'b0;
  endtask

  task automatic configure(input int width, input int height, input logic [1:0] mode,
                           input logic [15:0] border);
    writeRegister(`CFG_WIDTH, 16'(width));
    writeRegister(`CFG_HEIGHT, 16'(height));
    writeRegister(`CFG_MODE, {14'd0, mode});
    writeRegister(`CFG_BORDER, border);
    modelWidth = width;
    modelHeight = height;
    modelGray = mode[`MODE_GRAY];
    modelDouble = mode[`MODE_DOUBLE];
    modelBorder = border;
  endtask

  // word source, sends a whole line per credit
  task automatic sendWords();
    int credits;
    int wordIndex;
    int stalled;
    int lineWords;
    logic [31:0] word;
    credits = 2;
    wordIndex = 0;
    stalled = 0;
    lineWords = lineWordCount();
    while (senderRun)
    begin
      @(negedge pixelClockIn);
      if (lineCredit)
        credits++;
      if (credits > 2)
      begin
        $display("more credits returned than buffer halves at %0d ns", $time);
        errorCount++;
        credits = 2;
      end
      @(posedge pixelClockIn);
      #1;
      if (lineWords > 0 && (wordIndex > 0 || credits > 0))
      begin
        if (wordIndex == 0)
          credits--;
        word = $urandom;
        wordValid = 1'b1;
        wordData = word;
        sentWords.push_back(word);
        wordIndex = (wordIndex + 1) % lineWords;
        stalled = 0;
      end
      else
      begin
        wordValid = 1'b0;
        if (lineWords > 0)
          stalled++;
        if (stalled == `H_TOTAL * `V_TOTAL)
        begin
          $display("word source waited a whole frame for a credit at %0d ns", $time);
          errorCount++;
        end
      end
    end
    wordValid = 1'b0;
  endtask

  // one frame at the ports, from the start of vertical sync to the next one
  task automatic captureFrame(input int frame);
    int line;
    int column;
    int syncCycles;
    int hSyncCycles;
    logic wasActive;
    line = 0;
    column = 0;
    syncCycles = 0;
    hSyncCycles = 0;
    wasActive = 1'b0;
    frameCredits = 0;
    while (verticalSync)
    begin
      syncCycles++;
      @(negedge pixelClockIn);
    end
    checkValue("verticalSync cycles per frame", syncCycles,
               (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL);
    while (!verticalSync)
    begin
      if (lineCredit)
        frameCredits++;
      if (horizontalSync)
        hSyncCycles++;
      checkValue("horizontalSync with activePixel", horizontalSync & activePixel, 0);
      if (activePixel)
      begin
        checkValue($sformatf("rgb565 at line %0d column %0d", line, column),
                   {red, green, blue}, expectedPixel(frame, line, column));
        column++;
      end
      else if (wasActive)
      begin
        checkValue("active pixels per line", column, `H_ACTIVE);
        line++;
        column = 0;
      end
      wasActive = activePixel;
      @(negedge pixelClockIn);
    end
    checkValue("active lines per frame", line, `V_ACTIVE);
    // every line outside vertical sync carries one sync pulse
    checkValue("horizontalSync cycles per frame", hSyncCycles,
               (`V_TOTAL - (`V_SYNC_END - `V_SYNC_START)) * (`H_SYNC_END - `H_SYNC_START));
  endtask

  task automatic showFrame();
    sentWords.delete();
    // config is active once vertical sync shows
    while (!verticalSync)
      @(negedge pixelClockIn);
    senderRun = 1'b1;
    fork
      sendWords();
      begin
        // the second frame shows lines sent on returned credits only
        captureFrame(0);
        captureFrame(1);
        senderRun = 1'b0;
      end
    join
  endtask

  task automatic testRaster();
    arstN = 1'b0;
    @(negedge pixelClockIn);
    checkValue("activePixel in reset", activePixel, 0);
    checkValue("lineCredit in reset", lineCredit, 0);
    resetDut();
    @(negedge pixelClockIn);
    checkValue("activePixel after reset", activePixel, 0);
    checkValue("lineCredit after reset", lineCredit, 0);
    configure(0, 0, 2'b00, 16'h0000);
    showFrame();
  endtask

  task automatic testBorderOnly();
    resetDut();
    configure(0, 12, 2'b00, 16'hA5C3);
    // too wide, the old width stays
    writeRegister(`CFG_WIDTH, 16'd100);
    showFrame();
    checkValue("lineCredit pulses per frame", frameCredits, 0);
  endtask

  task automatic testRgbWindow();
    resetDut();
    configure(32, 6, 2'b00, 16'h1234);
    showFrame();
  endtask

  task automatic testGrayscale();
    resetDut();
    configure(32, 6, 2'b01 << `MODE_GRAY, 16'hF81F);
    showFrame();
  endtask

  task automatic testDoubling();
    resetDut();
    configure(32, 6, 2'b01 << `MODE_DOUBLE, 16'h07E0);
    showFrame();
  endtask

  task automatic testCredits();
    resetDut();
    configure(40, 8, 2'b00, 16'h001F);
    showFrame();
    checkValue("lineCredit pulses per frame", frameCredits, 8);
  endtask

  initial
  begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles)
    begin
      @(posedge pixelClockIn);
      cycleCount++;
    end
    $display("timeout after %0d cycles with %0d errors so far", timeoutCycles, errorCount);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    arstN = 1'b0;
    cfgWrite = 1'b0;
    cfgAddress = 2'd0;
    cfgData = 16'd0;
    wordValid = 1'b0;
    wordData = 32'd0;
    senderRun = 1'b0;
    errorCount = 0;
    checkCount = 0;
    frameCredits = 0;
    modelWidth = 0;
    modelHeight = 0;
    modelGray = 1'b0;
    modelDouble = 1'b0;
    modelBorder = 16'd0;
    void'($urandom(32'h77e6));
    testRaster();
    testBorderOnly();
    testRgbWindow();
    testGrayscale();
    testDoubling();
    testCredits();
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* design/screens.sv */
module screens (
  input  logic        pixelClockIn,
  input  logic        arstN,
  input  logic        cfgWrite,
  input  logic [1:0]  cfgAddress,
  input  logic [15:0] cfgData,
  input  logic        wordValid,
  input  logic [31:0] wordData,
  output logic        lineCredit,
  output logic [4:0]  red,
  output logic [5:0]  green,
  output logic [4:0]  blue,
  output logic        horizontalSync,
  output logic        verticalSync,
  output logic        activePixel
);
  import screenPkg::*;

  bufferWord readWord;
  logic [4:0] readAddress;
  logic [1:0] laneSelect;
  logic readAdvance;
  logic inWindow;

  rasterBus raster ();
  configBus configuration ();

  screenTiming timing (
    .pixelClockIn (pixelClockIn),
    .arstN        (arstN),
    .raster       (raster.source)
  );

  displayConfig registers (
    .pixelClockIn  (pixelClockIn),
    .arstN         (arstN),
    .raster        (raster.sink),
    .cfgWrite      (cfgWrite),
    .cfgAddress    (cfgAddress),
    .cfgData       (cfgData),
    .configuration (configuration.source)
  );

  lineBuffer buffer (
    .pixelClockIn  (pixelClockIn),
    .arstN         (arstN),
    .configuration (configuration.sink),
    .wordValid     (wordValid),
    .wordData      (wordData),
    .readAddress   (readAddress),
    .readAdvance   (readAdvance),
    .readWord      (readWord)
  );

  graphicsWindow window (
    .pixelClockIn  (pixelClockIn),
    .arstN         (arstN),
    .raster        (raster.sink),
    .configuration (configuration.sink),
    .inWindow      (inWindow),
    .readAddress   (readAddress),
    .laneSelect    (laneSelect),
    .readAdvance   (readAdvance),
    .lineCredit    (lineCredit)
  );

  pixelMixer mixer (
    .pixelClockIn   (pixelClockIn),
    .arstN          (arstN),
    .raster         (raster.sink),
    .configuration  (configuration.sink),
    .inWindow       (inWindow),
    .laneSelect     (laneSelect),
    .readWord       (readWord),
    .red            (red),
    .green          (green),
    .blue           (blue),
    .horizontalSync (horizontalSync),
    .verticalSync   (verticalSync),
    .activePixel    (activePixel)
  );

endmodule

/* design/pixelMixer.sv */
module pixelMixer (
  input  logic                 pixelClockIn,
  input  logic                 arstN,
  rasterBus.sink               raster,
  configBus.sink               configuration,
  input  logic                 inWindow,
  input  logic [1:0]           laneSelect,
  input  screenPkg::bufferWord readWord,
  output logic [4:0]           red,
  output logic [5:0]           green,
  output logic [4:0]           blue,
  output logic                 horizontalSync,
  output logic                 verticalSync,
  output logic                 activePixel
);

  logic [1:0] hSyncDelay;
  logic [1:0] vSyncDelay;
  logic [1:0] activeDelay;
  logic inWindowDelay;
  logic [1:0] laneDelay;
  logic [7:0] grayByte;
  logic [15:0] grayPixel;
  logic [15:0] windowPixel;
  logic [15:0] outputPixel;

  // two stages to meet the buffer read data
  always_ff @(posedge pixelClockIn or negedge arstN)
  begin
    if (!arstN)
    begin
      hSyncDelay <= 2'd0;
      vSyncDelay <= 2'd0;
      activeDelay <= 2'd0;
      inWindowDelay <= 1'b0;
      horizontalSync <= 1'b0;
      verticalSync <= 1'b0;
      activePixel <= 1'b0;
    end
    else
    begin
      hSyncDelay <= {hSyncDelay[0], raster.hSync};
      vSyncDelay <= {vSyncDelay[0], raster.vSync};
      activeDelay <= {activeDelay[0], raster.requestPixel};
      inWindowDelay <= inWindow;
      horizontalSync <= hSyncDelay[1];
      verticalSync <= vSyncDelay[1];
      activePixel <= activeDelay[1];
    end
  end

  always_comb
  begin
    grayByte = readWord.gray[laneDelay];
    // gray to RGB565 by keeping the top bits
    grayPixel = {grayByte[7:3], grayByte[7:2], grayByte[7:3]};
    windowPixel = configuration.gray ? grayPixel : readWord.rgb[laneDelay[0]];
    if (!activeDelay[1])
      outputPixel = 16'd0;
    else if (inWindowDelay)
      outputPixel = windowPixel;
    else
      outputPixel = configuration.borderColor;
  end

  always_ff @(posedge pixelClockIn)
  begin
    laneDelay <= laneSelect;
    red <= outputPixel[15:11];
    green <= outputPixel[10:5];
    blue <= outputPixel[4:0];
  end

endmodule

/* design/graphicsWindow.sv */
`include "screen_macros.svh"

module graphicsWindow (
  input  logic       pixelClockIn,
  input  logic       arstN,
  rasterBus.sink     raster,
  configBus.sink     configuration,
  output logic       inWindow,
  output logic [4:0] readAddress,
  output logic [1:0] laneSelect,
  output logic       readAdvance,
  output logic       lineCredit
);

  logic [6:0] leftMargin;
  logic [6:0] rightEdge;
  logic [4:0] topMargin;
  logic [4:0] bottomEdge;
  logic [6:0] columnCount;
  logic [6:0] column;
  logic [6:0] sourceColumn;
  logic windowHit;
  logic lastPixel;
  logic windowEnd;

  // centred window
  assign leftMargin = 7'((`H_ACTIVE - configuration.graphicsWidth) >> 1);
  assign rightEdge = leftMargin + configuration.graphicsWidth;
  assign topMargin = 5'((`V_ACTIVE - configuration.graphicsHeight) >> 1);
  assign bottomEdge = topMargin + configuration.graphicsHeight;

  assign windowHit = raster.requestPixel &&
                     (raster.pixelIndex >= leftMargin) && (raster.pixelIndex < rightEdge) &&
                     (raster.lineIndex >= topMargin) && (raster.lineIndex < bottomEdge);

  // pixel 0 of a line starts from an empty count
  assign column = raster.newLine ? 7'd0 : columnCount;
  assign sourceColumn = configuration.double ? column >> 1 : column;
  assign lastPixel = windowHit && (column == configuration.graphicsWidth - 7'd1);

  always_ff @(posedge pixelClockIn or negedge arstN)
  begin
    if (!arstN)
    begin
      columnCount <= 7'd0;
      inWindow <= 1'b0;
      windowEnd <= 1'b0;
    end
    else
    begin
      columnCount <= windowHit ? column + 7'd1 : column;
      inWindow <= windowHit;
      windowEnd <= lastPixel;
    end
  end

  always_ff @(posedge pixelClockIn)
  begin
    readAddress <= configuration.gray ? sourceColumn[6:2] : sourceColumn[5:1];
    laneSelect <= configuration.gray ? sourceColumn[1:0] : {1'b0, sourceColumn[0]};
  end

  // line fully read, hand the half back to the source
  assign readAdvance = windowEnd;
  assign lineCredit = windowEnd;

endmodule

/* design/lineBuffer.sv */
`include "screen_macros.svh"

module lineBuffer (
  input  logic                pixelClockIn,
  input  logic                arstN,
  configBus.sink              configuration,
  input  logic                wordValid,
  input  screenPkg::bufferWord wordData,
  input  logic [4:0]          readAddress,
  input  logic                readAdvance,
  output screenPkg::bufferWord readWord
);
  import screenPkg::*;

  bufferWord memory [2 * `BUFFER_WORDS];
  logic [6:0] sourcePixels;
  logic [5:0] wordsPerLine;
  logic [4:0] writePointer;
  logic writeHalf;
  logic readHalf;
  logic lineDone;

  // source pixels per line, then packed into words, both rounded up
  assign sourcePixels = configuration.double ? (configuration.graphicsWidth + 7'd1) >> 1
                                             : configuration.graphicsWidth;
  assign wordsPerLine = configuration.gray ? 6'((sourcePixels + 7'd3) >> 2)
                                           : 6'((sourcePixels + 7'd1) >> 1);
  assign lineDone = ({1'b0, writePointer} + 6'd1) >= wordsPerLine;

  always_ff @(posedge pixelClockIn)
  begin
    if (wordValid)
      memory[{writeHalf, writePointer}] <= wordData;
    readWord <= memory[{readHalf, readAddress}];
  end

  always_ff @(posedge pixelClockIn or negedge arstN)
  begin
    if (!arstN)
    begin
      writePointer <= 5'd0;
      writeHalf <= 1'b0;
      readHalf <= 1'b0;
    end
    else
    begin
      if (wordValid)
      begin
        writePointer <= lineDone ? 5'd0 : writePointer + 5'd1;
        writeHalf <= writeHalf ^ lineDone;
      end
      if (readAdvance)
        readHalf <= ~readHalf;
    end
  end

  // a word never lands beyond the line it belongs to
  writeInsideLine : assert property (@(posedge pixelClockIn) disable iff (!arstN)
    wordValid |-> ({1'b0, writePointer} < wordsPerLine) && (wordsPerLine <= `BUFFER_WORDS));

endmodule

/* design/displayConfig.sv */
`include "screen_macros.svh"

module displayConfig (
  input  logic        pixelClockIn,
  input  logic        arstN,
  rasterBus.sink      raster,
  input  logic        cfgWrite,
  input  logic [1:0]  cfgAddress,
  input  logic [15:0] cfgData,
  configBus.source    configuration
);

  logic [6:0] widthShadow;
  logic [6:0] widthActive;
  logic [4:0] heightShadow;
  logic [4:0] heightActive;
  logic [1:0] modeShadow;
  logic [1:0] modeActive;
  logic [15:0] borderShadow;
  logic [15:0] borderActive;

  always_ff @(posedge pixelClockIn or negedge arstN)
  begin
    if (!arstN)
    begin
      widthShadow <= 7'd0;
      heightShadow <= 5'd0;
      modeShadow <= 2'd0;
      borderShadow <= 16'd0;
      widthActive <= 7'd0;
      heightActive <= 5'd0;
      modeActive <= 2'd0;
      borderActive <= 16'd0;
    end
    else
    begin
      if (cfgWrite)
      begin
        case (cfgAddress)
          // oversized windows keep the previous size
          `CFG_WIDTH:
            if (cfgData <= `H_ACTIVE)
              widthShadow <= cfgData[6:0];
          `CFG_HEIGHT:
            if (cfgData <= `V_ACTIVE)
              heightShadow <= cfgData[4:0];
          `CFG_MODE:
            modeShadow <= cfgData[1:0];
          default:
            borderShadow <= cfgData;
        endcase
      end
      // frame boundary, so a frame is drawn with one setting
      if (raster.newScreen)
      begin
        widthActive <= widthShadow;
        heightActive <= heightShadow;
        modeActive <= modeShadow;
        borderActive <= borderShadow;
      end
    end
  end

  assign configuration.graphicsWidth = widthActive;
  assign configuration.graphicsHeight = heightActive;
  assign configuration.gray = modeActive[`MODE_GRAY];
  assign configuration.double = modeActive[`MODE_DOUBLE];
  assign configuration.borderColor = borderActive;

  windowFitsScreen : assert property (@(posedge pixelClockIn) disable iff (!arstN)
    (widthActive <= `H_ACTIVE) && (heightActive <= `V_ACTIVE));

endmodule

/* design/screenTiming.sv */
`include "screen_macros.svh"

module screenTiming (
  input  logic     pixelClockIn,
  input  logic     arstN,
  rasterBus.source raster
);

  logic [6:0] nextPixel;
  logic [4:0] nextLine;

  always_comb
  begin
    nextPixel = raster.pixelIndex + 7'd1;
    nextLine = raster.lineIndex;
    if (raster.pixelIndex == 7'(`H_TOTAL - 1))
    begin
      nextPixel = 7'd0;
      if (raster.lineIndex == 5'(`V_TOTAL - 1))
        nextLine = 5'd0;
      else
        nextLine = raster.lineIndex + 5'd1;
    end
  end

  // decode from the next position so every flag lines up with the counters
  always_ff @(posedge pixelClockIn or negedge arstN)
  begin
    if (!arstN)
    begin
      raster.pixelIndex <= 7'd0;
      raster.lineIndex <= 5'd0;
      raster.requestPixel <= 1'b0;
      raster.hSync <= 1'b0;
      raster.vSync <= 1'b0;
      raster.newScreen <= 1'b0;
      raster.newLine <= 1'b0;
    end
    else
    begin
      raster.pixelIndex <= nextPixel;
      raster.lineIndex <= nextLine;
      raster.requestPixel <= (nextPixel < `H_ACTIVE) && (nextLine < `V_ACTIVE);
      raster.hSync <= (nextPixel >= `H_SYNC_START) && (nextPixel < `H_SYNC_END);
      raster.vSync <= (nextLine >= `V_SYNC_START) && (nextLine < `V_SYNC_END);
      raster.newScreen <= (nextPixel == 7'd0) && (nextLine == 5'(`V_SYNC_START));
      raster.newLine <= (nextPixel == 7'd0);
    end
  end

  // sync pulse must sit in horizontal blanking
  hSyncInBlanking : assert property (@(posedge pixelClockIn) disable iff (!arstN)
    !(raster.hSync && raster.requestPixel));

endmodule

/* design/screenBuses.sv */
interface rasterBus;
  logic [6:0] pixelIndex;
  logic [4:0] lineIndex;
  logic requestPixel;
  logic hSync;
  logic vSync;
  logic newScreen;
  logic newLine;

  modport source (output pixelIndex, lineIndex, requestPixel, hSync, vSync, newScreen, newLine);
  modport sink (input pixelIndex, lineIndex, requestPixel, hSync, vSync, newScreen, newLine);
endinterface

interface configBus;
  logic [6:0] graphicsWidth;
  logic [4:0] graphicsHeight;
  logic gray;
  logic double;
  // RGB565
  logic [15:0] borderColor;

  modport source (output graphicsWidth, graphicsHeight, gray, double, borderColor);
  modport sink (input graphicsWidth, graphicsHeight, gray, double, borderColor);
endinterface

/* design/screenPkg.sv */
package screenPkg;

  // one buffer word, two RGB565 pixels or four gray bytes
  // element 0 sits in the low bits in both views
  typedef union packed
  {
    logic [1:0][15:0] rgb;
    logic [3:0][7:0] gray;
  } bufferWord;

endpackage

/* design/screen_macros.svh */
`ifndef SCREEN_MACROS_SVH
`define SCREEN_MACROS_SVH

// horizontal raster in pixels
`define H_ACTIVE 64
`define H_TOTAL 80
`define H_SYNC_START 66
`define H_SYNC_END 72

// vertical raster in lines
`define V_ACTIVE 12
`define V_TOTAL 16
`define V_SYNC_START 13
`define V_SYNC_END 15

// words per half of the ping-pong buffer
`define BUFFER_WORDS 32

// register addresses
`define CFG_WIDTH 2'd0
`define CFG_HEIGHT 2'd1
`define CFG_MODE 2'd2
`define CFG_BORDER 2'd3

// mode register bits
`define MODE_GRAY 0
`define MODE_DOUBLE 1

`endif
